/* Makefile */
TOP := av_config_tb
SIM := obj_dir/V$(TOP)

$(SIM): verilog.f $(wildcard logic/*.sv bench/*.sv include/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f --top-module $(TOP)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* bench/av_config_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "av_init_defines.svh"

module av_config_tb
	import av_init_pkg::*;
();

	// One write is 29 bit periods of four quarters
	localparam int WRITE_CYCLES    = 116 * `AV_I2C_QUARTER;
	localparam int WATCHDOG_CYCLES = 3 * 21 * WRITE_CYCLES + 2000;
	localparam int NACK_ENTRY      = 12;
	localparam int PASSES          = 2;

	logic          clk;
	logic          rst_n;
	logic          start;
	logic          sda_in;
	logic          sclk;
	logic          sda_oe;
	logic          done;
	logic          ack_error;
	logic          word_strobe;
	logic [23:0]   word_bytes;
	logic          word_acked;
	logic [2:0]    byte_total;
	int            write_count;

	av_init_word_u expected [0:`AV_INIT_ENTRIES-1];
	// Per pass whether a start pulse opens it and which entry gets refused
	logic          pass_restart [0:PASSES-1];
	int            pass_nack    [0:PASSES-1];

	av_config_top av_config_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.sda_in    (sda_in),
		.sclk      (sclk),
		.sda_oe    (sda_oe),
		.done      (done),
		.ack_error (ack_error)
	);

	i2c_target_model i2c_target_model_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.sclk        (sclk),
		.sda_oe      (sda_oe),
		.nack_index  (NACK_ENTRY),
		.sda_in      (sda_in),
		.word_strobe (word_strobe),
		.word_bytes  (word_bytes),
		.word_acked  (word_acked),
		.byte_total  (byte_total),
		.write_count (write_count)
	);

	task automatic report_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic void build_expected();
		logic [8:0]  codec_values  [0:`AV_CODEC_ENTRIES-1];
		logic [15:0] decoder_pairs [0:`AV_DECODER_ENTRIES-1];
		codec_values = '{`AV_CODEC_LINE_IN_L, `AV_CODEC_LINE_IN_R, `AV_CODEC_LINE_OUT_L,
			`AV_CODEC_LINE_OUT_R, `AV_CODEC_ADC_PATH, `AV_CODEC_DAC_PATH, `AV_CODEC_POWER,
			`AV_CODEC_FORMAT, `AV_CODEC_SAMPLING, `AV_CODEC_ACTIVE};
		decoder_pairs = '{`AV_DEC_INPUT_CTRL, `AV_DEC_OUTPUT_CTRL, `AV_DEC_EXT_OUTPUT_CTRL,
			`AV_DEC_AUTODETECT, `AV_DEC_BRIGHTNESS, `AV_DEC_HUE, `AV_DEC_ADI_CTRL,
			`AV_DEC_POWER_MGMT, `AV_DEC_CHROMA_GAIN_1, `AV_DEC_CHROMA_GAIN_2};
		for (int i = 0; i < `AV_CODEC_ENTRIES; i++) begin
			expected[i] = '0;
			expected[i].codec_view.dev      = `AV_CODEC_DEV;
			// Codec register number is the table position
			expected[i].codec_view.reg_addr = 7'(i);
			expected[i].codec_view.data     = codec_values[i];
		end
		// Decoder block follows the codec block
		for (int i = 0; i < `AV_DECODER_ENTRIES; i++) begin
			expected[`AV_CODEC_ENTRIES + i] = '0;
			expected[`AV_CODEC_ENTRIES + i].decoder_view.dev      = `AV_DECODER_DEV;
			expected[`AV_CODEC_ENTRIES + i].decoder_view.reg_addr = decoder_pairs[i][15:8];
			expected[`AV_CODEC_ENTRIES + i].decoder_view.data     = decoder_pairs[i][7:0];
		end
	endfunction

	task automatic check_idle_levels(input string when);
		assert (sclk === 1'b1 && sda_oe === 1'b0)
			else report_error($sformatf("bus not idle %s", when));
		assert (done === 1'b0 && ack_error === 1'b0)
			else report_error($sformatf("done or ack_error set %s", when));
	endtask

	// Compare through the view that belongs to the entry's device
	task automatic check_write(input int idx, input av_init_word_u got);
		av_init_word_u want;
		want = expected[idx];
		if (idx < `AV_CODEC_ENTRIES) begin
			assert (got.codec_view.dev == want.codec_view.dev &&
				got.codec_view.reg_addr == want.codec_view.reg_addr &&
				got.codec_view.data == want.codec_view.data)
				else report_error($sformatf("codec entry %0d got %h expected %h",
					idx, got, want));
		end else begin
			assert (got.decoder_view.dev == want.decoder_view.dev &&
				got.decoder_view.reg_addr == want.decoder_view.reg_addr &&
				got.decoder_view.data == want.decoder_view.data)
				else report_error($sformatf("decoder entry %0d got %h expected %h",
					idx, got, want));
		end
	endtask

	task automatic wait_for_write();
		do begin
			@(negedge clk);
		end while (!word_strobe);
	endtask

	// Expected index moves only on an acked write, so a retry must repeat it
	task automatic walk_table(input int nack_entry);
		int            idx;
		logic          nack_seen;
		av_init_word_u got;
		idx       = 0;
		nack_seen = 1'b0;
		while (idx < `AV_INIT_ENTRIES) begin
			wait_for_write();
			got = word_bytes;
			assert (byte_total == 3'd3)
				else report_error($sformatf("entry %0d sent %0d bytes", idx, byte_total));
			check_write(idx, got);
			assert (ack_error == nack_seen)
				else report_error($sformatf("ack_error %b at entry %0d", ack_error, idx));
			assert (!done)
				else report_error($sformatf("done high before entry %0d", idx));
			if (word_acked) begin
				idx++;
			end else begin
				assert (idx == nack_entry && !nack_seen)
					else report_error($sformatf("unexpected refusal at entry %0d", idx));
				nack_seen = 1'b1;
			end
		end
		assert (nack_seen == (nack_entry >= 0))
			else report_error("refused write was never retried");
	endtask

	task automatic finish_pass(input logic expect_error, input int writes_total);
		int waited;
		waited = 0;
		while (!done && waited < WRITE_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		assert (done) else report_error("done did not rise after the last write");
		assert (ack_error == expect_error)
			else report_error($sformatf("ack_error %b at done", ack_error));
		// Quiet bus once the table is through
		repeat (2 * WRITE_CYCLES) begin
			@(negedge clk);
			assert (sclk === 1'b1 && sda_oe === 1'b0 && !word_strobe && done)
				else report_error("bus activity after done");
		end
		// Twenty writes per pass plus one retry for a refused entry
		assert (write_count == writes_total)
			else report_error($sformatf("%0d bus writes seen, expected %0d",
				write_count, writes_total));
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		assert (!done && !ack_error) else report_error("start left done or ack_error set");
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, the init sequence never completed");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int writes_total;
		rst_n = 1'b0;
		start = 1'b0;
		writes_total = 0;
		build_expected();
		pass_restart[0] = 1'b0;
		pass_nack[0]    = NACK_ENTRY;
		pass_restart[1] = 1'b1;
		pass_nack[1]    = -1;
		repeat (10) begin
			@(negedge clk);
			check_idle_levels("during reset");
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_levels("after reset");
		for (int p = 0; p < PASSES; p++) begin
			if (pass_restart[p]) begin
				pulse_start();
			end
			writes_total += `AV_INIT_ENTRIES;
			if (pass_nack[p] >= 0) begin
				writes_total++;
			end
			walk_table(pass_nack[p]);
			finish_pass(pass_nack[p] >= 0, writes_total);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/i2c_target_model.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_target_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        sclk,
	input  logic        sda_oe,
	input  int          nack_index,
	output logic        sda_in,
	output logic        word_strobe,
	output logic [23:0] word_bytes,
	output logic        word_acked,
	output logic [2:0]  byte_total,
	output int          write_count
);

	logic       line;
	logic       pull;
	logic       prev_sclk;
	logic       prev_sda;
	logic [7:0] shreg;
	logic [3:0] bit_count;
	logic       in_ack;
	logic [2:0] byte_count;
	logic       refuse;
	logic       refused;

	// Open-drain data line, low when either side pulls
	assign line   = !(sda_oe || pull);
	assign sda_in = line;

	// Bus sampled once per clk, away from the edges that move it
	always_ff @(negedge clk) begin
		if (!rst_n) begin
			pull        <= 1'b0;
			prev_sclk   <= 1'b1;
			prev_sda    <= 1'b1;
			shreg       <= '0;
			bit_count   <= '0;
			in_ack      <= 1'b0;
			byte_count  <= '0;
			refuse      <= 1'b0;
			refused     <= 1'b0;
			word_strobe <= 1'b0;
			word_bytes  <= '0;
			word_acked  <= 1'b0;
			byte_total  <= '0;
			write_count <= 0;
		end else begin
			prev_sclk   <= sclk;
			prev_sda    <= line;
			word_strobe <= 1'b0;
			if (prev_sclk && sclk && prev_sda && !line) begin
				// Start, SDA falls with SCL high
				bit_count  <= '0;
				in_ack     <= 1'b0;
				byte_count <= '0;
				// Chosen write gets no ack, only the first time round
				refuse     <= (write_count == nack_index) && !refused;
			end else if (prev_sclk && sclk && !prev_sda && line) begin
				// Stop, report the whole write
				word_strobe <= 1'b1;
				word_acked  <= !refuse;
				byte_total  <= byte_count;
				write_count <= write_count + 1;
				refused     <= refused || refuse;
			end else if (!prev_sclk && sclk) begin
				// Data bit valid on the rising edge
				if (bit_count < 4'd8) begin
					shreg     <= {shreg[6:0], line};
					bit_count <= bit_count + 4'd1;
				end
			end else if (prev_sclk && !sclk) begin
				if (in_ack) begin
					// Ack slot over, let go of the line
					in_ack    <= 1'b0;
					pull      <= 1'b0;
					bit_count <= '0;
				end else if (bit_count == 4'd8) begin
					in_ack     <= 1'b1;
					pull       <= !refuse;
					word_bytes <= {word_bytes[15:0], shreg};
					byte_count <= byte_count + 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* include/av_init_defines.svh */
`ifndef AV_INIT_DEFINES_SVH
`define AV_INIT_DEFINES_SVH

// Bus write addresses, R/W bit already zero
`define AV_CODEC_DEV            8'h34
`define AV_DECODER_DEV          8'h40

// Audio codec register data, 9 bits each
`define AV_CODEC_LINE_IN_L      9'h01A
`define AV_CODEC_LINE_IN_R      9'h01A
`define AV_CODEC_LINE_OUT_L     9'h07B
`define AV_CODEC_LINE_OUT_R     9'h07B
`define AV_CODEC_ADC_PATH       9'h0F8
`define AV_CODEC_DAC_PATH       9'h006
`define AV_CODEC_POWER          9'h000
`define AV_CODEC_FORMAT         9'h001
`define AV_CODEC_SAMPLING       9'h002
`define AV_CODEC_ACTIVE         9'h001

// Video decoder writes, register in the upper byte and data in the lower
`define AV_DEC_INPUT_CTRL       16'h0040
`define AV_DEC_OUTPUT_CTRL      16'h030C
`define AV_DEC_EXT_OUTPUT_CTRL  16'h0445
`define AV_DEC_AUTODETECT       16'h0757
`define AV_DEC_BRIGHTNESS       16'h0A00
`define AV_DEC_HUE              16'h0B00
`define AV_DEC_ADI_CTRL         16'h0E00
`define AV_DEC_POWER_MGMT       16'h0F00
`define AV_DEC_CHROMA_GAIN_1    16'h2DF4
`define AV_DEC_CHROMA_GAIN_2    16'h2E00

// Table sizes
`define AV_CODEC_ENTRIES        10
`define AV_DECODER_ENTRIES      10
`define AV_INIT_ENTRIES         (`AV_CODEC_ENTRIES + `AV_DECODER_ENTRIES)
`define AV_ROM_ADDR_W           6

// clk cycles per quarter of a bus clock period
`define AV_I2C_QUARTER          4

`endif

/* logic/av_config_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "av_init_defines.svh"

module av_config_top
	import av_init_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic sda_in,
	output logic sclk,
	output logic sda_oe,
	output logic done,
	output logic ack_error
);

	logic [`AV_ROM_ADDR_W-1:0] rom_address;
	av_init_word_u             rom_data;
	logic                      send;
	logic                      busy;
	logic                      finished;
	logic                      acked;

	// Flat codec plus decoder table
	av_init_rom av_init_rom_i (
		.rom_address (rom_address),
		.rom_data    (rom_data)
	);

	// Walks the table, retries on no ack
	av_init_sequencer av_init_sequencer_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.busy        (busy),
		.finished    (finished),
		.acked       (acked),
		.rom_address (rom_address),
		.send        (send),
		.done        (done),
		.ack_error   (ack_error)
	);

	// Two-wire bus writer, three bytes per word
	i2c_byte_writer i2c_byte_writer_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.send     (send),
		.word     (rom_data),
		.busy     (busy),
		.finished (finished),
		.acked    (acked),
		.sclk     (sclk),
		.sda_oe   (sda_oe),
		.sda_in   (sda_in)
	);

endmodule

`default_nettype wire

/* logic/av_init_pkg.sv */
`default_nettype none

package av_init_pkg;

	// One init ROM word, always sent as three bytes MSB first
	// Both devices see byte 2 as the write address
	typedef union packed {
		// Codec packs a 7-bit register and 9 data bits
		// into the lower two bytes
		struct packed {
			logic [7:0] dev;
			logic [6:0] reg_addr;
			logic [8:0] data;
		} codec_view;

		// Decoder uses plain byte register and byte data
		struct packed {
			logic [7:0] dev;
			logic [7:0] reg_addr;
			logic [7:0] data;
		} decoder_view;
	} av_init_word_u;

endpackage

`default_nettype wire

/* logic/av_init_rom.sv */
`timescale 1ns/1ns
`default_nettype none

`include "av_init_defines.svh"

module av_init_rom
	import av_init_pkg::*;
(
	input  logic [`AV_ROM_ADDR_W-1:0] rom_address,
	output av_init_word_u             rom_data
);

	av_init_word_u codec_data;
	av_init_word_u decoder_data;

	// Audio codec, addresses 0 to 9
	codec_init_rom codec_init_rom_i (
		.rom_address (rom_address),
		.rom_data    (codec_data)
	);

	// Video decoder, addresses 10 to 19
	decoder_init_rom decoder_init_rom_i (
		.rom_address (rom_address),
		.rom_data    (decoder_data)
	);

	// Each table is zero outside its range, so OR gives one flat table
	assign rom_data = codec_data | decoder_data;

endmodule

`default_nettype wire

/* logic/av_init_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "av_init_defines.svh"

module av_init_sequencer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  logic                      busy,
	input  logic                      finished,
	input  logic                      acked,
	output logic [`AV_ROM_ADDR_W-1:0] rom_address,
	output logic                      send,
	output logic                      done,
	output logic                      ack_error
);

	// FSM encoding
	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_LAUNCH = 2'd1;
	localparam logic [1:0] S_WAIT   = 2'd2;
	localparam logic [1:0] S_SETTLE = 2'd3;

	logic [1:0] state;
	logic       last_entry;

	assign last_entry = (rom_address == (`AV_INIT_ENTRIES - 1));

	// Send pulse for one cycle in LAUNCH
	// A restart in that cycle suppresses it
	assign send = (state == S_LAUNCH) && !start;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// Settle then launch entry 0, so the table runs after reset
			state       <= S_SETTLE;
			rom_address <= '0;
			done        <= 1'b0;
			ack_error   <= 1'b0;
		end else if (start && !busy) begin
			// Restart from the top of the table
			state       <= S_SETTLE;
			rom_address <= '0;
			done        <= 1'b0;
			ack_error   <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					state <= S_IDLE;
				end
				S_LAUNCH: begin
					state <= S_WAIT;
				end
				S_WAIT: begin
					if (finished) begin
						if (!acked) begin
							// Same address goes out again
							ack_error <= 1'b1;
							state     <= S_SETTLE;
						end else if (last_entry) begin
							done  <= 1'b1;
							state <= S_IDLE;
						end else begin
							rom_address <= rom_address + 1'b1;
							state       <= S_SETTLE;
						end
					end
				end
				// One spare cycle, next send lands two after finished
				S_SETTLE: begin
					state <= S_LAUNCH;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/codec_init_rom.sv */
`timescale 1ns/1ns
`default_nettype none

`include "av_init_defines.svh"

module codec_init_rom
	import av_init_pkg::*;
(
	input  logic [`AV_ROM_ADDR_W-1:0] rom_address,
	output av_init_word_u             rom_data
);

	// Register number in [15:9], data in [8:0]
	logic [15:0] entry;

	// Codec table, register number follows the address
	always_comb begin
		case (rom_address)
			6'd0:    entry = {7'h00, `AV_CODEC_LINE_IN_L};
			6'd1:    entry = {7'h01, `AV_CODEC_LINE_IN_R};
			6'd2:    entry = {7'h02, `AV_CODEC_LINE_OUT_L};
			6'd3:    entry = {7'h03, `AV_CODEC_LINE_OUT_R};
			6'd4:    entry = {7'h04, `AV_CODEC_ADC_PATH};
			6'd5:    entry = {7'h05, `AV_CODEC_DAC_PATH};
			6'd6:    entry = {7'h06, `AV_CODEC_POWER};
			6'd7:    entry = {7'h07, `AV_CODEC_FORMAT};
			6'd8:    entry = {7'h08, `AV_CODEC_SAMPLING};
			// Activate last, after format and clocks are set
			6'd9:    entry = {7'h09, `AV_CODEC_ACTIVE};
			default: entry = '0;
		endcase
	end

	// Zero outside the codec range so the tables can be ORed
	always_comb begin
		rom_data = '0;
		if (rom_address < `AV_CODEC_ENTRIES) begin
			rom_data.codec_view.dev      = `AV_CODEC_DEV;
			rom_data.codec_view.reg_addr = entry[15:9];
			rom_data.codec_view.data     = entry[8:0];
		end
	end

endmodule

`default_nettype wire

/* logic/decoder_init_rom.sv */
`timescale 1ns/1ns
`default_nettype none

`include "av_init_defines.svh"

module decoder_init_rom
	import av_init_pkg::*;
(
	input  logic [`AV_ROM_ADDR_W-1:0] rom_address,
	output av_init_word_u             rom_data
);

	// Register byte over data byte
	logic [15:0] entry;
	logic        in_range;

	// Decoder entries sit right after the codec ones
	assign in_range = (rom_address >= `AV_CODEC_ENTRIES) &&
		(rom_address < (`AV_CODEC_ENTRIES + `AV_DECODER_ENTRIES));

	always_comb begin
		case (rom_address)
			// Input select first
			6'd10:   entry = `AV_DEC_INPUT_CTRL;
			6'd11:   entry = `AV_DEC_OUTPUT_CTRL;
			6'd12:   entry = `AV_DEC_EXT_OUTPUT_CTRL;
			6'd13:   entry = `AV_DEC_AUTODETECT;
			// Picture adjust left at neutral
			6'd14:   entry = `AV_DEC_BRIGHTNESS;
			6'd15:   entry = `AV_DEC_HUE;
			6'd16:   entry = `AV_DEC_ADI_CTRL;
			6'd17:   entry = `AV_DEC_POWER_MGMT;
			// Manual chroma gain pair
			6'd18:   entry = `AV_DEC_CHROMA_GAIN_1;
			6'd19:   entry = `AV_DEC_CHROMA_GAIN_2;
			default: entry = '0;
		endcase
	end

	always_comb begin
		rom_data = '0;
		if (in_range) begin
			rom_data.decoder_view.dev      = `AV_DECODER_DEV;
			rom_data.decoder_view.reg_addr = entry[15:8];
			rom_data.decoder_view.data     = entry[7:0];
		end
	end

endmodule

`default_nettype wire

/* logic/i2c_byte_writer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "av_init_defines.svh"

module i2c_byte_writer
	import av_init_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          send,
	input  av_init_word_u word,
	output logic          busy,
	output logic          finished,
	output logic          acked,
	output logic          sclk,
	output logic          sda_oe,
	input  logic          sda_in
);

	localparam int QW = $clog2(`AV_I2C_QUARTER + 1);

	// Bit periods: start, 27 data and ack, stop
	localparam logic [4:0] START_BIT = 5'd0;
	localparam logic [4:0] STOP_BIT  = 5'd28;
	// Ninth slot of each byte
	localparam logic [3:0] ACK_SLOT  = 4'd8;

	logic [QW-1:0] qcnt;
	logic [1:0]    quarter;
	logic [4:0]    bitno;
	logic [3:0]    slot;
	logic [23:0]   shift;
	logic          nack;
	logic          tick;
	logic          period_end;
	logic          in_data;

	// End of a quarter
	assign tick       = busy && (qcnt == QW'(`AV_I2C_QUARTER - 1));
	assign period_end = tick && (quarter == 2'd3);
	assign in_data    = (bitno != START_BIT) && (bitno != STOP_BIT);

	assign finished = period_end && (bitno == STOP_BIT);
	assign acked    = !nack;

	// Line levels per quarter
	always_comb begin
		// Idle, both lines released
		sclk   = 1'b1;
		sda_oe = 1'b0;
		if (busy) begin
			if (bitno == START_BIT) begin
				// SDA falls while SCL high, SCL drops in q3
				sclk   = (quarter != 2'd3);
				sda_oe = (quarter != 2'd0);
			end else if (bitno == STOP_BIT) begin
				// SDA rises in q2 while SCL high
				sclk   = (quarter != 2'd0);
				sda_oe = (quarter < 2'd2);
			end else begin
				// High in q1 and q2, data moves only at q0 while low
				sclk   = (quarter == 2'd1) || (quarter == 2'd2);
				sda_oe = (slot != ACK_SLOT) && !shift[23];
			end
		end
	end

	// Control state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			qcnt    <= '0;
			quarter <= '0;
			bitno   <= '0;
			slot    <= '0;
			nack    <= 1'b0;
		end else if (!busy) begin
			if (send) begin
				busy    <= 1'b1;
				qcnt    <= '0;
				quarter <= '0;
				bitno   <= START_BIT;
				slot    <= '0;
				nack    <= 1'b0;
			end
		end else begin
			qcnt <= tick ? '0 : qcnt + 1'b1;
			if (tick) begin
				quarter <= quarter + 1'b1;
			end
			// Mid-high sample of each ack slot, high means no ack
			if (tick && (quarter == 2'd1) && in_data && (slot == ACK_SLOT) && sda_in) begin
				nack <= 1'b1;
			end
			if (period_end) begin
				if (bitno == STOP_BIT) begin
					busy <= 1'b0;
				end else begin
					bitno <= bitno + 1'b1;
				end
				if (in_data) begin
					slot <= (slot == ACK_SLOT) ? '0 : slot + 1'b1;
				end
			end
		end
	end

	// Payload, MSB out first
	always_ff @(posedge clk) begin
		if (!busy && send) begin
			shift <= word;
		end else if (period_end && in_data && (slot != ACK_SLOT)) begin
			shift <= {shift[22:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
logic/av_init_pkg.sv
logic/codec_init_rom.sv
logic/decoder_init_rom.sv
logic/av_init_rom.sv
logic/av_init_sequencer.sv
logic/i2c_byte_writer.sv
logic/av_config_top.sv
bench/i2c_target_model.sv
bench/av_config_tb.sv
